// File: build.f
+incdir+.
mem_pkg.sv
ram_2port.sv
store_align.sv
load_align.sv
mmio_decode.sv
uart_port_ctrl.sv
mem_top.sv
tb_mem_top.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator and run, exit status reports pass or fail
verilator --binary --timing --assert -f build.f --top-module tb_mem_top -o tb_mem_top \
    && ./obj_dir/tb_mem_top \
    || exit 1

// File: tb_mem_vectors.svh
`ifndef TB_MEM_VECTORS_SVH
`define TB_MEM_VECTORS_SVH

// columns: op, addr, funct3, writedata, fifo wait cycles, expected, expected valid
// a wait of 255 draws a random length, uart rows at address 4 ignore the expected column

localparam logic [1:0] OP_LOAD  = 2'd0;
localparam logic [1:0] OP_STORE = 2'd1;
localparam logic [1:0] OP_FETCH = 2'd2;

typedef struct packed {
    logic [1:0]  op;
    logic [31:0] addr;
    logic [2:0]  funct3;
    logic [31:0] wdata;
    logic [7:0]  waits;
    logic [31:0] exp;
    logic        chk;
} vec_t;

localparam int N_VEC = 26;

vec_t vec_tab [N_VEC] = '{
    '{OP_STORE, 32'h100,   SIZE_W,  32'hdeadbeef, 8'd0,   32'h0,        1'b0},
    '{OP_LOAD,  32'h100,   SIZE_W,  32'h0,        8'd0,   32'hdeadbeef, 1'b1},
    '{OP_STORE, 32'h101,   SIZE_B,  32'h000000a5, 8'd0,   32'h0,        1'b0},
    '{OP_LOAD,  32'h101,   SIZE_B,  32'h0,        8'd0,   32'hffffffa5, 1'b1},
    '{OP_LOAD,  32'h101,   SIZE_BU, 32'h0,        8'd0,   32'h000000a5, 1'b1},
    '{OP_STORE, 32'h102,   SIZE_H,  32'h00008123, 8'd0,   32'h0,        1'b0},
    '{OP_LOAD,  32'h102,   SIZE_H,  32'h0,        8'd0,   32'hffff8123, 1'b1},
    '{OP_LOAD,  32'h102,   SIZE_HU, 32'h0,        8'd0,   32'h00008123, 1'b1},
    '{OP_LOAD,  32'h100,   SIZE_W,  32'h0,        8'd0,   32'h8123a5ef, 1'b1},
    '{OP_LOAD,  32'h100,   SIZE_BU, 32'h0,        8'd0,   32'h000000ef, 1'b1},
    '{OP_LOAD,  32'h103,   SIZE_B,  32'h0,        8'd0,   32'hffffff81, 1'b1},
    '{OP_STORE, 32'h200,   SIZE_H,  32'h12347fff, 8'd0,   32'h0,        1'b0},
    '{OP_LOAD,  32'h200,   SIZE_H,  32'h0,        8'd0,   32'h00007fff, 1'b1},
    '{OP_STORE, 32'h0,     SIZE_W,  32'hcafe1234, 8'd0,   32'h00001234, 1'b1},  // seg
    '{OP_FETCH, 32'h0,     SIZE_W,  32'h0,        8'd0,   32'h0,        1'b0},
    '{OP_FETCH, 32'h100,   SIZE_W,  32'h0,        8'd0,   32'h8123a5ef, 1'b1},
    '{OP_STORE, 32'h4,     SIZE_W,  32'h0000003c, 8'd0,   32'h0,        1'b0},
    '{OP_STORE, 32'h4,     SIZE_W,  32'h0000015a, 8'd5,   32'h0,        1'b0},
    '{OP_STORE, 32'h4,     SIZE_B,  32'h00000077, 8'd255, 32'h0,        1'b0},
    '{OP_FETCH, 32'h200,   SIZE_W,  32'h0,        8'd0,   32'h0,        1'b0},
    '{OP_LOAD,  32'h4,     SIZE_BU, 32'h0,        8'd0,   32'h0,        1'b0},
    '{OP_LOAD,  32'h4,     SIZE_W,  32'h0,        8'd7,   32'h0,        1'b0},
    '{OP_LOAD,  32'h4,     SIZE_W,  32'h0,        8'd255, 32'h0,        1'b0},
    '{OP_STORE, 32'h1fffc, SIZE_W,  32'h01020304, 8'd0,   32'h0,        1'b0},
    '{OP_LOAD,  32'h1fffe, SIZE_HU, 32'h0,        8'd0,   32'h00000102, 1'b1},
    '{OP_FETCH, 32'h1fffc, SIZE_W,  32'h0,        8'd0,   32'h01020304, 1'b1}
};

`endif

// File: tb_mem_top.sv
`timescale 1ns/100ps

module tb_mem_top import mem_pkg::*; ();

    `include "tb_mem_vectors.svh"

    localparam int RESET_CYCLES = 16;
    localparam int MAX_CYCLES = 40 * N_VEC + RESET_CYCLES;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic [31:0] addr_inst = 32'h0;
    logic [31:0] addr = 32'h8;
    logic [31:0] writedata = 32'h0;
    logic [2:0] funct3 = 3'd2;
    logic readctrl = 1'b0;
    logic writectrl = 1'b0;
    logic empty = 1'b0;
    logic full = 1'b0;
    logic [7:0] uart_in = 8'h0;
    logic [31:0] inst_out;
    logic [31:0] readdata;
    logic clken;
    logic rdreq;
    logic wrreq;
    logic [7:0] uart_out;
    logic [15:0] seg_io;

    logic [31:0] shadow [0:32767];
    integer seed = 32'h9a3e_6f58;
    int cycles = 0;
    int rd_count = 0;
    int wr_count = 0;
    int rd_base;
    int wr_base;
    logic [7:0] wr_byte;
    logic [7:0] rx_head = 8'h0;  // next byte the rx fifo hands out

    mem_top i_dut (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] fill_word(int idx);
        return {16'(idx) ^ 16'h5a5a, ~16'(idx)};
    endfunction

    task automatic fail_run(string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                               $time, name, got, exp));
    endtask

    task automatic check_seg(logic [15:0] got, logic [15:0] exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED at %0t: seg_io got %h expected %h",
                               $time, got, exp));
    endtask

    task automatic check_byte(logic [7:0] got, logic [7:0] exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED at %0t: uart_out got %h expected %h",
                               $time, got, exp));
    endtask

    // strobes seen since the row started
    task automatic compare_strobes(int n_rd, int n_wr);
        check_word("rdreq count", 32'(rd_count - rd_base), 32'(n_rd));
        check_word("wrreq count", 32'(wr_count - wr_base), 32'(n_wr));
    endtask

    // reference load rule for little endian lanes with extension
    function automatic logic [31:0] expect_load(logic [31:0] w, logic [1:0] off, logic [2:0] f3);
        logic [31:0] b;
        logic [31:0] h;
        b = w >> (8 * off);
        h = w >> (16 * off[1]);
        case (f3)
            3'd0:    return {{24{b[7]}}, b[7:0]};
            3'd4:    return {24'd0, b[7:0]};
            3'd1:    return {{16{h[15]}}, h[15:0]};
            3'd5:    return {16'd0, h[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic shadow_store(logic [31:0] a, logic [2:0] f3, logic [31:0] d);
        int idx;
        idx = int'(a[16:2]);
        if (f3 == 3'd0 || f3 == 3'd4)
            shadow[idx][8*a[1:0] +: 8] = d[7:0];
        else if (f3 == 3'd1 || f3 == 3'd5)
            shadow[idx][16*a[1] +: 16] = d[15:0];
        else
            shadow[idx] = d;
    endtask

    // fifo models react to the strobes on the clock edge
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES)
            fail_run("timeout: the run took more cycles than the table allows");
        if (!reset && rdreq) begin
            rd_count <= rd_count + 1;
            uart_in <= rx_head;  // normal mode q follows the read strobe
        end
        if (!reset && wrreq) begin
            wr_count <= wr_count + 1;
            wr_byte <= uart_out;
        end
    end

    // ************************************************************************
    // uart access with a fifo wait of n cycles
    // ************************************************************************

    task automatic uart_access(vec_t v);
        int n;
        int stalls;
        logic [31:0] hold_rd;
        logic [31:0] hold_inst;
        logic [31:0] fetch_addr;
        logic [7:0] head;
        n = (v.waits == 8'd255) ? (($random(seed) & 7) + 1) : int'(v.waits);
        head = 8'($random(seed));
        if (head == uart_in)
            head = ~head;  // differs from the byte still on the fifo output
        rx_head = head;
        stalls = 0;
        fetch_addr = addr_inst;
        hold_rd = readdata;
        addr = v.addr;
        funct3 = v.funct3;
        writedata = v.wdata;
        readctrl = (v.op == OP_LOAD);
        writectrl = (v.op == OP_STORE);
        empty = (v.op == OP_LOAD) && (n > 0);
        full = (v.op == OP_STORE) && (n > 0);
        @(posedge clk);
        @(negedge clk);
        while (!clken) begin
            check_word("readdata", readdata, hold_rd);
            if (stalls == 0)
                hold_inst = inst_out;
            else
                check_word("inst_out", inst_out, hold_inst);
            addr_inst = fetch_addr ^ 32'h40;  // inst_out must not follow
            stalls++;
            if (stalls >= n) begin
                empty = 1'b0;
                full = 1'b0;
            end
            @(negedge clk);
        end
        check_word("stall cycles", 32'(stalls), 32'(n));
        if (v.op == OP_LOAD)
            check_word("readdata", readdata, {24'd0, head});
        else
            check_byte(wr_byte, v.wdata[7:0]);
        addr_inst = fetch_addr;
    endtask

    initial begin
        vec_t v;
        logic uart_row;
        for (int i = 0; i < 32768; i++) begin
            shadow[i] = fill_word(i);
            i_dut.i_ram.mem[i] = fill_word(i);
        end
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        check_word("clken", {31'd0, clken}, 32'd1);
        check_seg(seg_io, 16'd0);
        for (int r = 0; r < N_VEC; r++) begin
            v = vec_tab[r];
            uart_row = (v.addr == 32'h4) && (v.op != OP_FETCH);
            rd_base = rd_count;
            wr_base = wr_count;
            if (uart_row) begin
                uart_access(v);
            end else if (v.op == OP_FETCH) begin
                addr_inst = v.addr;
                @(posedge clk);
                @(negedge clk);
                check_word("inst_out", inst_out, shadow[int'(v.addr[16:2])]);
                if (v.chk)
                    check_word("inst_out", inst_out, v.exp);
            end else begin
                addr = v.addr;
                funct3 = v.funct3;
                writedata = v.wdata;
                readctrl = (v.op == OP_LOAD);
                writectrl = (v.op == OP_STORE);
                @(posedge clk);
                @(negedge clk);
                check_word("clken", {31'd0, clken}, 32'd1);
                if (v.op == OP_LOAD) begin
                    check_word("readdata", readdata,
                               expect_load(shadow[int'(v.addr[16:2])], v.addr[1:0], v.funct3));
                    if (v.chk)
                        check_word("readdata", readdata, v.exp);
                end else if (v.addr == 32'h0) begin
                    check_seg(seg_io, v.wdata[15:0]);
                    if (v.chk)
                        check_seg(seg_io, v.exp[15:0]);
                end else begin
                    shadow_store(v.addr, v.funct3, v.wdata);
                end
            end
            compare_strobes(uart_row && (v.op == OP_LOAD), uart_row && (v.op == OP_STORE));
            readctrl = 1'b0;
            writectrl = 1'b0;
            addr = 32'h8;
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: mem_top.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module mem_top import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    // core side
    input  logic [`MEM_DATA_W-1:0] addr_inst,
    output logic [`MEM_DATA_W-1:0] inst_out,
    input  logic [`MEM_DATA_W-1:0] addr,
    input  logic [`MEM_DATA_W-1:0] writedata,
    output logic [`MEM_DATA_W-1:0] readdata,
    input  logic [2:0]             funct3,
    input  logic                   readctrl,
    input  logic                   writectrl,
    output logic                   clken,
    // uart fifos
    input  logic                   empty,
    input  logic                   full,
    input  logic [7:0]             uart_in,
    output logic [7:0]             uart_out,
    output logic                   rdreq,
    output logic                   wrreq,
    // display
    output logic [15:0]            seg_io
);

    mem_size_e              funct3_e;
    dev_sel_e               dev_sel;
    logic                   ram_we;
    logic [3:0]             ram_be;
    logic [`MEM_DATA_W-1:0] ram_wdata;
    logic [`MEM_DATA_W-1:0] ram_rdata;
    logic [`MEM_DATA_W-1:0] inst_rdata;
    mem_size_e              size_q;
    logic [1:0]             byte_off_q;
    logic [`MEM_DATA_W-1:0] load_data;
    logic [`MEM_DATA_W-1:0] read_mux;

    assign funct3_e = mem_size_e'(funct3);

    mmio_decode i_decode (
        .clk        (clk),
        .reset      (reset),
        .addr       (addr),
        .funct3     (funct3_e),
        .writedata  (writedata),
        .writectrl  (writectrl),
        .readctrl   (readctrl),
        .run        (clken),
        .load_data  (load_data),
        .uart_in    (uart_in),
        .dev_sel    (dev_sel),
        .ram_we     (ram_we),
        .size_q     (size_q),
        .byte_off_q (byte_off_q),
        .read_mux   (read_mux),
        .seg_io     (seg_io)
    );

    store_align i_store (
        .funct3    (funct3_e),
        .byte_off  (addr[1:0]),
        .writedata (writedata),
        .we_in     (ram_we),
        .ram_be    (ram_be),
        .ram_wdata (ram_wdata)
    );

    ram_2port i_ram (
        .clk        (clk),
        .inst_addr  (addr_inst[`MEM_ADDR_BITS+1:2]),
        .inst_rdata (inst_rdata),
        .data_addr  (addr[`MEM_ADDR_BITS+1:2]),
        .data_be    (ram_be),
        .data_we    (ram_we),
        .data_wdata (ram_wdata),
        .data_rdata (ram_rdata)
    );

    load_align i_load (
        .size_q     (size_q),
        .byte_off_q (byte_off_q),
        .ram_rdata  (ram_rdata),
        .load_data  (load_data)
    );

    uart_port_ctrl i_uart_ctrl (
        .clk        (clk),
        .reset      (reset),
        .dev_sel    (dev_sel),
        .readctrl   (readctrl),
        .writectrl  (writectrl),
        .writedata  (writedata),
        .empty      (empty),
        .full       (full),
        .read_mux   (read_mux),
        .inst_rdata (inst_rdata),
        .rdreq      (rdreq),
        .wrreq      (wrreq),
        .uart_out   (uart_out),
        .clken      (clken),
        .readdata   (readdata),
        .inst_out   (inst_out)
    );

endmodule

// File: uart_port_ctrl.sv
`timescale 1ns/100ps

module uart_port_ctrl import mem_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  dev_sel_e    dev_sel,
    input  logic        readctrl,
    input  logic        writectrl,
    input  logic [31:0] writedata,
    input  logic        empty,
    input  logic        full,
    input  logic [31:0] read_mux,
    input  logic [31:0] inst_rdata,
    output logic        rdreq,
    output logic        wrreq,
    output logic [7:0]  uart_out,
    output logic        clken,
    output logic [31:0] readdata,
    output logic [31:0] inst_out
);

    stall_state_e state;
    stall_state_e state_next;
    logic         uart_rd;
    logic         uart_wr;
    logic         run_q;       // clken of the previous cycle
    logic [7:0]   wbyte_q;
    logic [31:0]  readdata_q;
    logic [31:0]  inst_q;

    assign uart_rd = readctrl && (dev_sel == DEV_UART);
    assign uart_wr = writectrl && (dev_sel == DEV_UART);

    // ************************************************************************
    // stall fsm and fifo strobes
    // ************************************************************************

    always_comb begin
        state_next = state;
        rdreq = 1'b0;
        wrreq = 1'b0;
        case (state)
            ST_RUN: begin
                if (uart_rd) begin
                    if (empty)
                        state_next = ST_WAIT_RD;
                    else
                        rdreq = 1'b1;
                end else if (uart_wr) begin
                    if (full)
                        state_next = ST_WAIT_WR;
                    else
                        wrreq = 1'b1;
                end
            end
            ST_WAIT_RD: begin
                if (!empty) begin
                    rdreq = 1'b1;  // byte shows up next cycle together with clken
                    state_next = ST_RUN;
                end
            end
            ST_WAIT_WR: begin
                if (!full) begin
                    wrreq = 1'b1;
                    state_next = ST_RUN;
                end
            end
            default: state_next = ST_RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_RUN;
            run_q <= 1'b1;
        end else begin
            state <= state_next;
            run_q <= clken;
        end
    end

    assign clken = (state == ST_RUN);

    // held copies for the stalled cycles
    always_ff @(posedge clk) begin
        if (clken) begin
            wbyte_q <= writedata[7:0];
            readdata_q <= readdata;
        end
        if (run_q)
            inst_q <= inst_rdata;
    end

    assign uart_out = clken ? writedata[7:0] : wbyte_q;
    assign readdata = clken ? read_mux : readdata_q;
    assign inst_out = run_q ? inst_rdata : inst_q;  // frozen after a stall cycle

    // a stall ends only through the fifo strobe that served it
    a_release_strobe: assert property (
        @(posedge clk) disable iff (reset) $rose(clken) |-> $past(rdreq || wrreq)
    );

    // the core keeps seeing its last result for the whole stall
    a_hold_readdata: assert property (
        @(posedge clk) disable iff (reset) !clken |-> $stable(readdata)
    );

endmodule

// File: mmio_decode.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module mmio_decode import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`MEM_DATA_W-1:0] addr,
    input  mem_size_e              funct3,
    input  logic [`MEM_DATA_W-1:0] writedata,
    input  logic                   writectrl,
    input  logic                   readctrl,
    input  logic                   run,
    input  logic [`MEM_DATA_W-1:0] load_data,
    input  logic [7:0]             uart_in,
    output dev_sel_e               dev_sel,
    output logic                   ram_we,
    output mem_size_e              size_q,
    output logic [1:0]             byte_off_q,
    output logic [`MEM_DATA_W-1:0] read_mux,
    output logic [15:0]            seg_io
);

    logic uart_rd_q;  // previous access was a uart read

    always_comb begin
        if (addr == `MEM_SEG_ADDR)
            dev_sel = DEV_SEG;
        else if (addr == `MEM_UART_ADDR)
            dev_sel = DEV_UART;
        else
            dev_sel = DEV_RAM;
    end

    assign ram_we = writectrl && run && (dev_sel == DEV_RAM);

    // seven segment register
    always_ff @(posedge clk) begin
        if (reset)
            seg_io <= 16'd0;
        else if (run && writectrl && (dev_sel == DEV_SEG))
            seg_io <= writedata[15:0];
    end

    // ************************************************************************
    // access info for the load returned next cycle
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (reset)
            uart_rd_q <= 1'b0;
        else if (run)
            uart_rd_q <= readctrl && (dev_sel == DEV_UART);
    end

    always_ff @(posedge clk) begin
        if (run) begin
            size_q <= funct3;
            byte_off_q <= addr[1:0];
        end
    end

    assign read_mux = uart_rd_q ? {{(`MEM_DATA_W-8){1'b0}}, uart_in} : load_data;

endmodule

// File: load_align.sv
`timescale 1ns/100ps

module load_align import mem_pkg::*; (
    input  mem_size_e   size_q,
    input  logic [1:0]  byte_off_q,
    input  logic [31:0] ram_rdata,
    output logic [31:0] load_data
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // little endian lane select
    always_comb begin
        case (byte_off_q)
            2'd0:    sel_byte = ram_rdata[7:0];
            2'd1:    sel_byte = ram_rdata[15:8];
            2'd2:    sel_byte = ram_rdata[23:16];
            default: sel_byte = ram_rdata[31:24];
        endcase
        sel_half = byte_off_q[1] ? ram_rdata[31:16] : ram_rdata[15:0];
    end

    // ************************************************************************
    // extension by access size
    // ************************************************************************

    always_comb begin
        case (size_q)
            SIZE_B:  load_data = {{24{sel_byte[7]}}, sel_byte};
            SIZE_BU: load_data = {24'd0, sel_byte};
            SIZE_H:  load_data = {{16{sel_half[15]}}, sel_half};
            SIZE_HU: load_data = {16'd0, sel_half};
            default: load_data = ram_rdata;  // word
        endcase
    end

endmodule

// File: store_align.sv
`timescale 1ns/100ps

module store_align import mem_pkg::*; (
    input  mem_size_e   funct3,
    input  logic [1:0]  byte_off,
    input  logic [31:0] writedata,
    input  logic        we_in,
    output logic [3:0]  ram_be,
    output logic [31:0] ram_wdata
);

    // data is replicated into every lane, the enables pick the target bytes
    always_comb begin
        ram_wdata = writedata;
        ram_be = 4'b1111;
        case (funct3)
            SIZE_B, SIZE_BU: begin
                ram_wdata = {4{writedata[7:0]}};
                ram_be = 4'b0001 << byte_off;
            end
            SIZE_H, SIZE_HU: begin
                ram_wdata = {2{writedata[15:0]}};
                ram_be = byte_off[1] ? 4'b1100 : 4'b0011;  // offset bit 0 ignored
            end
            default: begin
                ram_be = 4'b1111;
            end
        endcase
        if (!we_in)
            ram_be = 4'b0000;
    end

endmodule

// File: ram_2port.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module ram_2port (
    input  logic                      clk,
    input  logic [`MEM_ADDR_BITS-1:0] inst_addr,
    output logic [`MEM_DATA_W-1:0]    inst_rdata,
    input  logic [`MEM_ADDR_BITS-1:0] data_addr,
    input  logic [3:0]                data_be,
    input  logic                      data_we,
    input  logic [`MEM_DATA_W-1:0]    data_wdata,
    output logic [`MEM_DATA_W-1:0]    data_rdata
);

    localparam int DEPTH = 1 << `MEM_ADDR_BITS;

    logic [`MEM_DATA_W-1:0] mem [0:DEPTH-1];

    // read-only instruction port
    always_ff @(posedge clk) begin
        inst_rdata <= mem[inst_addr];
    end

    // data port reads the old word on a write cycle
    always_ff @(posedge clk) begin
        data_rdata <= mem[data_addr];
        for (int i = 0; i < 4; i++) begin
            if (data_we && data_be[i])
                mem[data_addr][8*i +: 8] <= data_wdata[8*i +: 8];
        end
    end

    // a write must land on a known word
    a_wr_in_range: assert property (
        @(posedge clk) (data_we && (data_be != 4'b0000)) |-> !$isunknown(data_addr)
    );

endmodule

// File: mem_pkg.sv
package mem_pkg;

    // ************************************************************************
    // shared types for the memory subsystem
    // ************************************************************************

    // rv32 load/store size, same encoding as funct3
    typedef enum logic [2:0] {
        SIZE_B  = 3'd0,
        SIZE_H  = 3'd1,
        SIZE_W  = 3'd2,
        SIZE_BU = 3'd4,
        SIZE_HU = 3'd5
    } mem_size_e;

    // uart stall control
    typedef enum logic [1:0] {
        ST_RUN     = 2'd0,  // core running, clken high
        ST_WAIT_RD = 2'd1,  // waiting for rx fifo data
        ST_WAIT_WR = 2'd2   // waiting for tx fifo space
    } stall_state_e;

    // target of a data access
    typedef enum logic [1:0] {
        DEV_RAM  = 2'd0,
        DEV_SEG  = 2'd1,
        DEV_UART = 2'd2
    } dev_sel_e;

endpackage

// File: mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// ****************************************************************************
// memory map and sizing
// ****************************************************************************

// ram word index comes from address bits 16..2
`define MEM_ADDR_BITS 15

// data path width of the core side
`define MEM_DATA_W 32

// memory mapped devices, full 32-bit address match
`define MEM_SEG_ADDR 32'd0   // seven segment register
`define MEM_UART_ADDR 32'd4  // uart byte channel

`endif
